/* rtl/dcache_pkg.sv */
// shared cache types; data and address are fixed at 32 bits, bit 31 marks the uncached region
package dcache_pkg;

    // one bus word
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // one enable per byte lane
    typedef logic [3:0] sel_t;

    // addresses with this bit set bypass the cache
    localparam int UNCACHED_BIT = 31;

    // one store FIFO entry
    typedef struct packed {
        addr_t adr;
        word_t dat;
        sel_t  sel;
    } uncached_store_t;

    // line request from the controller to the line mover
    typedef enum logic {
        LINE_READ,
        LINE_WRITE
    } line_op_t;

endpackage

/* rtl/set_array.sv */
// one write port and a registered read; a same-address write shows on the next read only
module set_array #(
    parameter int  DEPTH   = 64,
    parameter type entry_t = logic
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // whole array clears so valid and dirty start low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            // old contents when read and write hit the same set
            rdata <= mem[raddr];
        end
    end

    index_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (raddr < DEPTH) && (!we || (waddr < DEPTH)));

endmodule

/* rtl/dcache_ctrl.sv */
// two ways, one request at a time; the CPU holds adr, sel and dat_w until ack; LINE_WORDS >= 2
module dcache_ctrl import dcache_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int SET_NUM    = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          we,
    input  sel_t                          sel,
    input  addr_t                         adr,
    input  word_t                         dat_w,
    output word_t                         dat_r,
    output logic                          ack,
    output logic                          line_req,
    output line_op_t                      line_op,
    output addr_t                         line_adr,
    output logic                          victim,
    input  logic                          line_done,
    input  logic                          fill_we,
    input  word_t                         fill_word,
    input  logic [$clog2(LINE_WORDS)-1:0] fill_idx,
    output word_t                         evict_word
);

    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int INDEX_W  = $clog2(SET_NUM);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    typedef enum logic [2:0] {
        LOOKUP,
        COMPARE,
        MISS_DIRTY,
        MISS_CLEAN,
        REFILL_DONE
    } state_t;

    state_t              state;
    logic [OFFSET_W-1:0] offset;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    tagv_t               tagv_q [2];
    tagv_t               tagv_new;
    logic                dirty_q [2];
    word_t               data_q [2][LINE_WORDS];
    logic [1:0]          hit;
    logic                hit_way;
    logic                pick;
    logic                store_hit;
    logic                refill_end;
    word_t               hit_word;
    word_t               merged;
    // one bit per set, points at the way to replace
    logic [SET_NUM-1:0]  lru;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t be);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return m;
    endfunction

    // address fields, held by the CPU for the whole request
    assign offset = adr[OFFSET_W+1:2];
    assign index  = adr[OFFSET_W+2 +: INDEX_W];
    assign tag    = adr[31 -: TAG_W];

    for (genvar w = 0; w < 2; w++) begin : g_hit
        assign hit[w] = tagv_q[w].valid && (tagv_q[w].tag == tag);
    end

    assign hit_way    = hit[1];
    assign hit_word   = data_q[hit_way][offset];
    assign merged     = merge_bytes(hit_word, dat_w, sel);
    assign store_hit  = (state == COMPARE) && (|hit) && we;
    assign refill_end = (state == MISS_CLEAN) && line_done;
    assign tagv_new   = '{valid: 1'b1, tag: tag};

    // empty way first, otherwise the LRU way
    always_comb begin
        if (!tagv_q[0].valid) begin
            pick = 1'b0;
        end else if (!tagv_q[1].valid) begin
            pick = 1'b1;
        end else begin
            pick = lru[index];
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        set_array #(.DEPTH(SET_NUM), .entry_t(tagv_t)) u_tagv (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (refill_end && (victim == 1'(w))),
            .waddr (index),
            .raddr (index),
            .wdata (tagv_new),
            .rdata (tagv_q[w])
        );

        // set by a store hit, cleared when the line is refilled
        set_array #(.DEPTH(SET_NUM), .entry_t(logic)) u_dirty (
            .clk   (clk),
            .rst_n (rst_n),
            .we    ((store_hit && (hit_way == 1'(w))) || (refill_end && (victim == 1'(w)))),
            .waddr (index),
            .raddr (index),
            .wdata (store_hit),
            .rdata (dirty_q[w])
        );

        for (genvar j = 0; j < LINE_WORDS; j++) begin : g_word
            set_array #(.DEPTH(SET_NUM), .entry_t(word_t)) u_data (
                .clk   (clk),
                .rst_n (rst_n),
                .we    ((fill_we && (victim == 1'(w)) && (fill_idx == OFFSET_W'(j))) ||
                        (store_hit && (hit_way == 1'(w)) && (offset == OFFSET_W'(j)))),
                .waddr (index),
                .raddr (index),
                .wdata (fill_we ? fill_word : merged),
                .rdata (data_q[w][j])
            );
        end
    end

    // writeback sends the victim's own tag, refill the request's
    assign line_req   = (state == MISS_DIRTY) || (state == MISS_CLEAN);
    assign line_op    = (state == MISS_DIRTY) ? LINE_WRITE : LINE_READ;
    assign line_adr   = (state == MISS_DIRTY) ?
                        {tagv_q[victim].tag, index, {(OFFSET_W + 2){1'b0}}} :
                        {tag, index, {(OFFSET_W + 2){1'b0}}};
    assign evict_word = data_q[victim][fill_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= LOOKUP;
            ack    <= 1'b0;
            victim <= 1'b0;
            lru    <= '0;
        end else begin
            ack <= 1'b0;
            case (state)
                LOOKUP: begin
                    // arrays latch the set on this edge
                    if (req && !ack) begin
                        state <= COMPARE;
                    end
                end
                COMPARE: begin
                    if (|hit) begin
                        ack        <= 1'b1;
                        lru[index] <= ~hit_way;
                        state      <= LOOKUP;
                    end else begin
                        victim <= pick;
                        state  <= (tagv_q[pick].valid && dirty_q[pick]) ? MISS_DIRTY : MISS_CLEAN;
                    end
                end
                MISS_DIRTY: begin
                    if (line_done) begin
                        state <= MISS_CLEAN;
                    end
                end
                MISS_CLEAN: begin
                    if (line_done) begin
                        state <= REFILL_DONE;
                    end
                end
                // one cycle for the new tag to reach the read port
                REFILL_DONE: state <= COMPARE;
                default: state <= LOOKUP;
            endcase
        end
    end

    // read word travels with ack
    always_ff @(posedge clk) begin
        if (state == COMPARE) begin
            dat_r <= hit_word;
        end
    end

    // the line mover relies on a steady request until done
    line_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (line_req && !line_done) |=> (line_req && $stable(line_op) && $stable(line_adr)));

endmodule

/* rtl/line_mover.sv */
// line_op and line_adr must hold while line_req is high; cyc stays high for the whole line
module line_mover import dcache_pkg::*; #(
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          line_req,
    input  line_op_t                      line_op,
    input  addr_t                         line_adr,
    output logic                          line_done,
    output logic                          fill_we,
    output logic [$clog2(LINE_WORDS)-1:0] fill_idx,
    output word_t                         fill_word,
    input  word_t                         evict_word,
    output logic                          m0_cyc,
    output logic                          m0_stb,
    output logic                          m0_we,
    output sel_t                          m0_sel,
    output addr_t                         m0_adr,
    output word_t                         m0_dat_w,
    input  word_t                         m0_dat_r,
    input  logic                          m0_ack
);

    localparam int OFFSET_W = $clog2(LINE_WORDS);

    logic                busy;
    logic                last;
    // word within the line
    logic [OFFSET_W-1:0] cnt;

    assign last = (cnt == OFFSET_W'(LINE_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!busy) begin
            busy <= line_req;
            cnt  <= '0;
        end else if (m0_ack) begin
            cnt <= cnt + 1'b1;
            if (last) begin
                busy <= 1'b0;
            end
        end
    end

    // full words at consecutive addresses
    assign m0_cyc   = busy;
    assign m0_stb   = busy;
    assign m0_we    = busy && (line_op == LINE_WRITE);
    assign m0_sel   = '1;
    assign m0_adr   = {line_adr[31:OFFSET_W+2], cnt, 2'b00};
    assign m0_dat_w = evict_word;

    // refill words go straight into the data array
    assign fill_we   = busy && m0_ack && (line_op == LINE_READ);
    assign fill_idx  = cnt;
    assign fill_word = m0_dat_r;
    assign line_done = busy && m0_ack && last;

    stb_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_stb && !m0_ack) |=> (m0_stb && $stable(m0_adr)));

endmodule

/* rtl/uncached_port.sv */
// blocking CPU side; stores retire in order from the FIFO, a read waits until the FIFO is empty
module uncached_port import dcache_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  logic  we,
    input  sel_t  sel,
    input  addr_t adr,
    input  word_t dat_w,
    output word_t dat_r,
    output logic  ack,
    output logic  m1_cyc,
    output logic  m1_stb,
    output logic  m1_we,
    output sel_t  m1_sel,
    output addr_t m1_adr,
    output word_t m1_dat_w,
    input  word_t m1_dat_r,
    input  logic  m1_ack
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        U_IDLE,
        U_WRITE,
        U_READ
    } ustate_t;

    ustate_t         state;
    uncached_store_t fifo [FIFO_DEPTH];
    uncached_store_t head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    // a held request is taken once, ack blocks the repeat
    assign push  = req && we && !full && !ack;
    assign pop   = (state == U_WRITE) && m1_ack;
    assign head  = fifo[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= '{adr: adr, dat: dat_w, sel: sel};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= U_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ack    <= 1'b0;
        end else begin
            // store acks on acceptance, read on return
            ack   <= push || ((state == U_READ) && m1_ack);
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case (state)
                U_IDLE: begin
                    if (!empty) begin
                        state <= U_WRITE;
                    end else if (req && !we && !ack) begin
                        state <= U_READ;
                    end
                end
                U_WRITE: begin
                    if (m1_ack) begin
                        state <= U_IDLE;
                    end
                end
                U_READ: begin
                    if (m1_ack) begin
                        state <= U_IDLE;
                    end
                end
                default: state <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == U_READ) && m1_ack) begin
            dat_r <= m1_dat_r;
        end
    end

    // reads use the CPU's held address and select
    assign m1_cyc   = (state != U_IDLE);
    assign m1_stb   = m1_cyc;
    assign m1_we    = (state == U_WRITE);
    assign m1_adr   = m1_we ? head.adr : adr;
    assign m1_sel   = m1_we ? head.sel : sel;
    assign m1_dat_w = head.dat;

    // occupancy never passes the ring size nor wraps below empty
    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(FIFO_DEPTH));

endmodule

/* rtl/wb_arbiter.sv */
// two masters, m0 first; a grant holds until its owner drops cyc, then the bus idles a cycle
module wb_arbiter import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  m0_cyc,
    input  logic  m0_stb,
    input  logic  m0_we,
    input  sel_t  m0_sel,
    input  addr_t m0_adr,
    input  word_t m0_dat_w,
    output word_t m0_dat_r,
    output logic  m0_ack,
    input  logic  m1_cyc,
    input  logic  m1_stb,
    input  logic  m1_we,
    input  sel_t  m1_sel,
    input  addr_t m1_adr,
    input  word_t m1_dat_w,
    output word_t m1_dat_r,
    output logic  m1_ack,
    output logic  mem_cyc,
    output logic  mem_stb,
    output logic  mem_we,
    output sel_t  mem_sel,
    output addr_t mem_adr,
    output word_t mem_dat_w,
    input  word_t mem_dat_r,
    input  logic  mem_ack
);

    // high selects m1
    logic gnt;
    logic gnt_q;
    logic lock_q;

    // free choice only when the bus was idle last cycle
    assign gnt = lock_q ? gnt_q : (!m0_cyc && m1_cyc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q  <= 1'b0;
            lock_q <= 1'b0;
        end else begin
            gnt_q  <= gnt;
            lock_q <= mem_cyc;
        end
    end

    assign mem_cyc   = gnt ? m1_cyc   : m0_cyc;
    assign mem_stb   = gnt ? m1_stb   : m0_stb;
    assign mem_we    = gnt ? m1_we    : m0_we;
    assign mem_sel   = gnt ? m1_sel   : m0_sel;
    assign mem_adr   = gnt ? m1_adr   : m0_adr;
    assign mem_dat_w = gnt ? m1_dat_w : m0_dat_w;

    // ack goes to the owner only
    assign m0_ack   = mem_ack && !gnt;
    assign m1_ack   = mem_ack && gnt;
    assign m0_dat_r = mem_dat_r;
    assign m1_dat_r = mem_dat_r;

    // an open transfer keeps its master until the slave answers
    transfer_owner_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_stb && !mem_ack) |=> (mem_stb && $stable(mem_we) && $stable(mem_adr)));

endmodule

/* rtl/dcache_top.sv */
// address bit 31 selects the uncached path; LINE_WORDS and SET_NUM must be powers of two
module dcache_top import dcache_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int SET_NUM    = 64,
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cpu_cyc,
    input  logic  cpu_stb,
    input  logic  cpu_we,
    input  sel_t  cpu_sel,
    input  addr_t cpu_adr,
    input  word_t cpu_dat_w,
    output word_t cpu_dat_r,
    output logic  cpu_ack,
    output logic  mem_cyc,
    output logic  mem_stb,
    output logic  mem_we,
    output sel_t  mem_sel,
    output addr_t mem_adr,
    output word_t mem_dat_w,
    input  word_t mem_dat_r,
    input  logic  mem_ack
);

    logic     c_req;
    logic     u_req;
    logic     c_ack;
    logic     u_ack;
    word_t    c_dat_r;
    word_t    u_dat_r;
    logic     line_req;
    logic     line_done;
    line_op_t line_op;
    addr_t    line_adr;
    logic     fill_we;
    word_t    fill_word;
    word_t    evict_word;
    logic [$clog2(LINE_WORDS)-1:0] fill_idx;
    logic     m0_cyc, m0_stb, m0_we, m0_ack;
    sel_t     m0_sel;
    addr_t    m0_adr;
    word_t    m0_dat_w, m0_dat_r;
    logic     m1_cyc, m1_stb, m1_we, m1_ack;
    sel_t     m1_sel;
    addr_t    m1_adr;
    word_t    m1_dat_w, m1_dat_r;

    // steer by region, only one side ever answers
    assign c_req     = cpu_cyc && cpu_stb && !cpu_adr[UNCACHED_BIT];
    assign u_req     = cpu_cyc && cpu_stb && cpu_adr[UNCACHED_BIT];
    assign cpu_ack   = c_ack || u_ack;
    assign cpu_dat_r = u_ack ? u_dat_r : c_dat_r;

    dcache_ctrl #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM)) u_ctrl (
        .clk (clk), .rst_n (rst_n), .req (c_req), .we (cpu_we), .sel (cpu_sel),
        .adr (cpu_adr), .dat_w (cpu_dat_w), .dat_r (c_dat_r), .ack (c_ack),
        .line_req (line_req), .line_op (line_op), .line_adr (line_adr), .victim (),
        .line_done (line_done), .fill_we (fill_we), .fill_word (fill_word),
        .fill_idx (fill_idx), .evict_word (evict_word)
    );

    line_mover #(.LINE_WORDS(LINE_WORDS)) u_mover (
        .clk (clk), .rst_n (rst_n), .line_req (line_req), .line_op (line_op),
        .line_adr (line_adr), .line_done (line_done), .fill_we (fill_we),
        .fill_idx (fill_idx), .fill_word (fill_word), .evict_word (evict_word),
        .m0_cyc (m0_cyc), .m0_stb (m0_stb), .m0_we (m0_we), .m0_sel (m0_sel),
        .m0_adr (m0_adr), .m0_dat_w (m0_dat_w), .m0_dat_r (m0_dat_r), .m0_ack (m0_ack)
    );

    uncached_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_uncached (
        .clk (clk), .rst_n (rst_n), .req (u_req), .we (cpu_we), .sel (cpu_sel),
        .adr (cpu_adr), .dat_w (cpu_dat_w), .dat_r (u_dat_r), .ack (u_ack),
        .m1_cyc (m1_cyc), .m1_stb (m1_stb), .m1_we (m1_we), .m1_sel (m1_sel),
        .m1_adr (m1_adr), .m1_dat_w (m1_dat_w), .m1_dat_r (m1_dat_r), .m1_ack (m1_ack)
    );

    // line mover on m0 wins ties
    wb_arbiter u_arb (
        .clk (clk), .rst_n (rst_n),
        .m0_cyc (m0_cyc), .m0_stb (m0_stb), .m0_we (m0_we), .m0_sel (m0_sel),
        .m0_adr (m0_adr), .m0_dat_w (m0_dat_w), .m0_dat_r (m0_dat_r), .m0_ack (m0_ack),
        .m1_cyc (m1_cyc), .m1_stb (m1_stb), .m1_we (m1_we), .m1_sel (m1_sel),
        .m1_adr (m1_adr), .m1_dat_w (m1_dat_w), .m1_dat_r (m1_dat_r), .m1_ack (m1_ack),
        .mem_cyc (mem_cyc), .mem_stb (mem_stb), .mem_we (mem_we), .mem_sel (mem_sel),
        .mem_adr (mem_adr), .mem_dat_w (mem_dat_w), .mem_dat_r (mem_dat_r),
        .mem_ack (mem_ack)
    );

endmodule

/* dv/tb_clock.sv */
// 20 ns free-running clock from time 0; rst_n low for the first 4 rising edges
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // released on the 4th edge, flops still see reset there
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* dv/tb_mem.sv */
// single-word Wishbone classic slave; 0 to 3 wait states, unwritten words return a fill pattern
module tb_mem import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  sel_t  sel,
    input  addr_t adr,
    input  word_t dat_w,
    output word_t dat_r,
    output logic  ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // sparse store, only written words are kept
    word_t words [addr_t];
    int    seed;
    int    wait_left;
    addr_t key;
    word_t w;

    initial begin
        seed      = 63;
        wait_left = 0;
        ack      <= 1'b0;
        dat_r    <= '0;
    end

    // every address bit shows up in the pattern
    function automatic word_t fill_pattern(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            dat_r    <= '0;
            wait_left = 0;
        end else begin
            ack <= 1'b0;
            // one ack per transfer, the next one starts after ack drops
            if (cyc && stb && !ack) begin
                if (wait_left > 0) begin
                    wait_left = wait_left - 1;
                end else begin
                    key = {adr[31:2], 2'b00};
                    w   = words.exists(key) ? words[key] : fill_pattern(key);
                    if (we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) begin
                                w[8*b +: 8] = dat_w[8*b +: 8];
                            end
                        end
                        words[key] = w;
                    end else begin
                        dat_r <= w;
                    end
                    ack      <= 1'b1;
                    // wait states for the next transfer
                    wait_left = $unsigned($random(seed)) % 4;
                end
            end
        end
    end

endmodule

/* dv/tb_dcache.sv */
// random CPU traffic from seed 63 against a word model; cached and uncached pools never alias
module tb_dcache import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_WORDS = 4;
    localparam int SET_NUM    = 64;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_OPS    = 600;
    localparam int ACK_LIMIT  = 500;
    localparam int LINE_BYTES = LINE_WORDS * 4;
    // same set, next tag
    localparam int TAG_STRIDE = SET_NUM * LINE_BYTES;
    localparam addr_t LINE_MASK = ~addr_t'(LINE_BYTES - 1);
    // set and offset bits only
    localparam addr_t SET_MASK  = addr_t'(TAG_STRIDE - 1);

    logic  clk;
    logic  rst_n;
    logic  cpu_cyc;
    logic  cpu_stb;
    logic  cpu_we;
    sel_t  cpu_sel;
    addr_t cpu_adr;
    word_t cpu_dat_w;
    word_t cpu_dat_r;
    logic  cpu_ack;
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    sel_t  mem_sel;
    addr_t mem_adr;
    word_t mem_dat_w;
    word_t mem_dat_r;
    logic  mem_ack;

    // expected memory image, byte merged on every store
    word_t           model [addr_t];
    bit              touched [addr_t];
    // uncached stores not yet seen on the memory bus
    uncached_store_t pending [$];
    uncached_store_t next_store;
    int              seed;
    int              loads_checked;
    // word number within the current line move
    int              line_word;

    tb_clock u_clock (.clk (clk), .rst_n (rst_n));

    dcache_top #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM), .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk (clk), .rst_n (rst_n), .cpu_cyc (cpu_cyc), .cpu_stb (cpu_stb),
        .cpu_we (cpu_we), .cpu_sel (cpu_sel), .cpu_adr (cpu_adr), .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r), .cpu_ack (cpu_ack), .mem_cyc (mem_cyc), .mem_stb (mem_stb),
        .mem_we (mem_we), .mem_sel (mem_sel), .mem_adr (mem_adr), .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r), .mem_ack (mem_ack)
    );

    tb_mem u_mem (
        .clk (clk), .rst_n (rst_n), .cyc (mem_cyc), .stb (mem_stb), .we (mem_we),
        .sel (mem_sel), .adr (mem_adr), .dat_w (mem_dat_w), .dat_r (mem_dat_r),
        .ack (mem_ack)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("error %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("error %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_sel(input sel_t got, input sel_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("error %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string name);
        if (got != exp) begin
            abort_run($sformatf("error %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // untouched words hold the tb_mem fill pattern
    function automatic word_t model_read(addr_t a);
        return model.exists(a) ? model[a] : ({a[15:0], a[31:16]} ^ 32'hc3a5_5a3c);
    endfunction

    function automatic void model_write(addr_t a, word_t d, sel_t be);
        word_t w;
        w = model_read(a);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        model[a] = w;
    endfunction

    // 4 tags over 2 sets overfill the 2 ways; 8 uncached words
    function automatic addr_t pick_address(input bit uncached);
        int tag;
        int set;
        int word;
        tag  = $unsigned($random(seed)) % 4;
        set  = $unsigned($random(seed)) % 2;
        word = $unsigned($random(seed)) % LINE_WORDS;
        if (uncached) begin
            return addr_t'(32'h8000_0100 + (tag * 2 + set) * 4);
        end
        return addr_t'(32'h2000 + tag * TAG_STRIDE + set * LINE_BYTES + word * 4);
    endfunction

    // one Wishbone classic cycle; lat counts edges from the drive edge to ack
    task automatic cpu_access(input bit we, input addr_t a, input sel_t be, input word_t d,
                              output word_t rd, output int lat);
        int n;
        bit got;
        @(posedge clk);
        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_we    <= we;
        cpu_sel   <= be;
        cpu_adr   <= a;
        cpu_dat_w <= d;
        n   = 0;
        got = 1'b0;
        while (!got && n < ACK_LIMIT) begin
            @(posedge clk);
            n++;
            // ack is stable at the falling edge
            @(negedge clk);
            got = cpu_ack;
        end
        if (!got) begin
            abort_run($sformatf("cpu_ack never came for the access to %h", a));
        end else begin
            rd  = cpu_dat_r;
            lat = n;
            @(posedge clk);
            cpu_cyc <= 1'b0;
            cpu_stb <= 1'b0;
            cpu_we  <= 1'b0;
        end
    endtask

    task automatic do_load(input addr_t a, input bit check_fast);
        word_t rd;
        int    lat;
        cpu_access(1'b0, a, 4'hf, '0, rd, lat);
        check_word(rd, model_read(a), "cpu_dat_r");
        if (check_fast) begin
            check_latency(lat, 2, "cpu_ack latency");
        end
        loads_checked++;
    endtask

    task automatic do_store(input addr_t a, input word_t d, input sel_t be);
        word_t           rd;
        int              lat;
        uncached_store_t st;
        // queued before the cycle, the FIFO may drain right after ack
        if (a[UNCACHED_BIT]) begin
            st.adr = a;
            st.dat = d;
            st.sel = be;
            pending.push_back(st);
        end
        model_write(a, d, be);
        cpu_access(1'b1, a, be, d, rd, lat);
    endtask

    // memory bus watch, one look per acked transfer
    always @(negedge clk) begin
        if (!rst_n || !mem_cyc) begin
            line_word = 0;
        end else if (mem_stb && mem_ack) begin
            if (!mem_adr[UNCACHED_BIT]) begin
                // line mover traffic, whole words in order through one line
                check_sel(mem_sel, 4'hf, "mem_sel");
                if (mem_we) begin
                    // the victim line sits in the set of the missing address
                    check_addr(mem_adr & SET_MASK,
                               (cpu_adr & SET_MASK & LINE_MASK) + addr_t'(line_word * 4),
                               "mem_adr writeback");
                end else begin
                    check_addr(mem_adr, (cpu_adr & LINE_MASK) + addr_t'(line_word * 4),
                               "mem_adr refill");
                end
                line_word++;
            end else if (mem_we) begin
                if (pending.size() == 0) begin
                    abort_run("an uncached store reached memory that the CPU never issued");
                end else begin
                    // program order
                    next_store = pending.pop_front();
                    check_addr(mem_adr, next_store.adr, "mem_adr");
                    check_word(mem_dat_w, next_store.dat, "mem_dat_w");
                    check_sel(mem_sel, next_store.sel, "mem_sel");
                end
            end else begin
                check_addr(mem_adr, cpu_adr, "mem_adr");
                check_sel(mem_sel, cpu_sel, "mem_sel");
            end
        end
    end

    initial begin : stimulus
        int    n;
        addr_t a;
        addr_t last_line;
        bit    have_line;
        bit    uncached;
        word_t d;
        sel_t  be;
        seed          = 63;
        loads_checked = 0;
        line_word     = 0;
        have_line     = 1'b0;
        last_line     = '0;
        cpu_cyc       = 1'b0;
        cpu_stb       = 1'b0;
        cpu_we        = 1'b0;
        cpu_sel       = '0;
        cpu_adr       = '0;
        cpu_dat_w     = '0;
        n = 0;
        while (!rst_n && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            abort_run("rst_n was never released");
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            uncached = ($unsigned($random(seed)) % 4) == 0;
            a        = pick_address(uncached);
            if (($random(seed) & 1) != 0) begin
                d  = $random(seed);
                be = sel_t'($random(seed));
                if (be == '0) begin
                    be = 4'hf;
                end
                do_store(a, d, be);
            end else begin
                // same line as the last cached access, so a hit
                do_load(a, !uncached && have_line && ((a & LINE_MASK) == last_line));
            end
            touched[a] = 1'b1;
            if (!uncached) begin
                last_line = a & LINE_MASK;
                have_line = 1'b1;
            end
        end
        // readback forces more evictions of dirty lines
        foreach (touched[k]) begin
            do_load(k, 1'b0);
        end
        n = 0;
        while (pending.size() != 0 && n < ACK_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (pending.size() != 0) begin
            abort_run("uncached stores never reached the memory bus");
        end else if (loads_checked == 0) begin
            abort_run("no load was checked");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* list.f */
rtl/dcache_pkg.sv
rtl/set_array.sv
rtl/dcache_ctrl.sv
rtl/line_mover.sv
rtl/uncached_port.sv
rtl/wb_arbiter.sv
rtl/dcache_top.sv
dv/tb_clock.sv
dv/tb_mem.sv
dv/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator; exits non-zero on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f list.f -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "compile step failed with status $status"
    exit $status
fi

./obj_dir/sim_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
